// ==== Makefile ====
# Verilator flow for the mono video card testbench

VERILATOR  ?= verilator
TOP        := mono_video_tb
RTL_TOP    := mono_video_top
FILELIST   := all.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := ** PASS **

LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qxF -- '$(PASS_TEXT)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
common/mono_video_pkg.sv
design/bus_phase.sv
design/raster_timing.sv
design/pixel_fetch.sv
design/mono_video_top.sv
bench/mono_video_assert.sv
bench/mono_video_tb.sv

// ==== bench/mono_video_assert.sv ====
`default_nettype none

// bus strobe and sync protocol checks for the card's blocks
module mono_video_assert #(
	parameter bit check_read = 1'b1,
	parameter bit check_sync = 1'b1
) (
	input logic pclk,
	input logic rst_n,
	input logic read,
	input logic [mono_video_pkg::slot_code_w-1:0] slot_code,
	input logic hs,
	input logic vs,
	input logic de
);
	import mono_video_pkg::*;

	// the slot code trails the raw bus slot by one pclk
	// so a video slot strobe meets cpu_a step 15 or video steps 0 to 14
	localparam logic [slot_code_w-1:0] code_pre_video = slot_code_of(slot_cpu_a, step_last);
	localparam logic [slot_code_w-1:0] code_video_last = slot_code_of(slot_video, step_last);

	logic in_video_window;

	assign in_video_window = (slot_code == code_pre_video) ||
		((slot_code[slot_code_w-1 -: 2] == slot_video) && (slot_code != code_video_last));

	generate
		if (check_read) begin : g_read
			// the strobe belongs to the video slot only
			read_in_video_slot: assert property (
				@(posedge pclk) disable iff (!rst_n) read |-> in_video_window
			) else $error("read strobe raised outside the video bus slot");
		end
		if (check_sync) begin : g_sync
			// no sync pulse inside the display window
			sync_idle_in_display: assert property (
				@(posedge pclk) disable iff (!rst_n) de |-> (hs && vs)
			) else $error("sync pulse overlaps the display enable");
		end
	endgenerate

endmodule

// fetch side sees the real strobe against the card's slot code
bind pixel_fetch mono_video_assert #(
	.check_read(1'b1),
	.check_sync(1'b0)
) u_fetch_assert (
	.pclk(pclk),
	.rst_n(rst_n),
	.read(read),
	.slot_code(slot_code),
	.hs(1'b1),
	.vs(1'b1),
	.de(de)
);

// raster side sees the syncs, no strobe here
bind raster_timing mono_video_assert #(
	.check_read(1'b0),
	.check_sync(1'b1)
) u_raster_assert (
	.pclk(pclk),
	.rst_n(rst_n),
	.read(1'b0),
	.slot_code(slot_code),
	.hs(hs),
	.vs(vs),
	.de(de)
);

`default_nettype wire

// ==== bench/mono_video_tb.sv ====
`default_nettype none

module mono_video_tb;
	import mono_video_pkg::*;

	// small frame: 256 pclk per line, 12 lines
	localparam int h_active = 128;
	localparam int h_fp = 16;
	localparam int h_sync = 32;
	localparam int h_bp2 = 48;
	localparam int v_active = 8;
	localparam int v_fp = 1;
	localparam int v_sync = 1;
	localparam int v_bp = 2;
	localparam logic [addr_w-1:0] base_addr = 23'h000100;

	localparam int line_len = h_prefetch + h_active + h_fp + h_sync + h_bp2;
	localparam int frame_len = line_len * (v_active + v_fp + v_sync + v_bp);
	localparam int words_per_line = h_active / 64;
	localparam int n_words = v_active * words_per_line;
	localparam int n_pixels = v_active * h_active;
	// frames 1 and 3 are checked, frame 2 takes the bclk phase jump
	localparam int n_frames = 4;
	localparam int cycle_limit = n_frames * frame_len + 200;

	// error classes for the closing line
	localparam int err_reset = 0;
	localparam int err_sync = 1;
	localparam int err_fetch = 2;
	localparam int err_pixel = 3;

	logic pclk = 1'b0;
	logic rst_n = 1'b0;
	logic bclk = 1'b1;
	bus_slot_e bus_cycle = slot_shifter;
	logic [data_w-1:0] data = '0;
	logic [addr_w-1:0] addr;
	logic read;
	logic hs;
	logic vs;
	logic de;
	logic [5:0] r;
	logic [5:0] g;
	logic [5:0] b;

	// bus rotation divider, starts off phase so the card has to lock
	logic [5:0] bus_div = 6'd5;
	logic [5:0] div_next;
	logic jump_req = 1'b0;

	integer seed = 32'h81fb_72de;
	logic [data_w-1:0] words [n_words];
	// expected pixel table, one row per display position
	int row_line [n_pixels];
	int row_col [n_pixels];
	logic row_pix [n_pixels];
	logic seen_pix [n_pixels];

	int err_cnt [4] = '{0, 0, 0, 0};
	int frame_no = 0;
	int line_cnt = 0;
	int col_cnt = 0;
	int strobe_cnt = 0;
	int tick = 0;
	int hs_fall_tick = 0;
	int vs_fall_tick = 0;
	logic hs_fall_seen = 1'b0;
	logic vs_fall_seen = 1'b0;
	logic de_q = 1'b0;
	logic read_q = 1'b0;
	logic hs_q = 1'b1;
	logic vs_q = 1'b1;
	logic finished = 1'b0;

	mono_video_top #(
		.h_active(h_active),
		.h_fp(h_fp),
		.h_sync(h_sync),
		.h_bp2(h_bp2),
		.v_active(v_active),
		.v_fp(v_fp),
		.v_sync(v_sync),
		.v_bp(v_bp),
		.base_addr(base_addr)
	) uut (
		.pclk(pclk),
		.rst_n(rst_n),
		.bclk(bclk),
		.bus_cycle(bus_cycle),
		.addr(addr),
		.read(read),
		.data(data),
		.hs(hs),
		.vs(vs),
		.de(de),
		.r(r),
		.g(g),
		.b(b)
	);

	// ----------------------------------------------------------------------
	// clocks, bus slots and memory
	// ----------------------------------------------------------------------

	initial begin
		forever #10 pclk = ~pclk;
	end

	// bclk high for steps 0 to 7, slot owner changes at step 0
	// a jump request skips 20 pclk of the rotation in one go
	assign div_next = bus_div + (jump_req ? 6'd21 : 6'd1);

	always @(posedge pclk) begin
		bus_div <= div_next;
		bclk <= (div_next[3:0] < 4'd8);
		bus_cycle <= bus_slot_e'(div_next[5:4]);
	end

	function automatic logic [data_w-1:0] memory_word(input logic [addr_w-1:0] a);
		logic [addr_w-1:0] offset;
		int idx;
		offset = (a - base_addr) >> 2;
		idx = int'(offset);
		if (idx < n_words) begin
			return words[idx];
		end
		return '0;
	endfunction

	// memory keeps the last word read until the next strobe
	always @(posedge pclk) begin
		if (read) begin
			data <= memory_word(addr);
		end
	end

	// ----------------------------------------------------------------------
	// tables and error reporting
	// ----------------------------------------------------------------------

	task automatic fill_tables;
		int word_i;
		int k;
		logic [15:0] lane_bits;
		for (int i = 0; i < n_words; i++) begin
			words[i] = {$random(seed), $random(seed)};
		end
		// lane k/16 of the word, pixel k%16 is its msb after shifting
		for (int i = 0; i < n_pixels; i++) begin
			row_line[i] = i / h_active;
			row_col[i] = i % h_active;
			word_i = row_line[i] * words_per_line + row_col[i] / 64;
			k = row_col[i] % 64;
			lane_bits = 16'(words[word_i] >> ((k / 16) * 16));
			lane_bits = lane_bits << (k % 16);
			row_pix[i] = !lane_bits[15];
			seen_pix[i] = 1'bx;
		end
	endtask

	task automatic report_error(input int kind, input string what);
		err_cnt[kind]++;
		$display("** Error at time %0t: %s", $time, what);
	endtask

	function automatic int total_errors();
		return err_cnt[err_reset] + err_cnt[err_sync] + err_cnt[err_fetch] + err_cnt[err_pixel];
	endfunction

	task automatic print_counts;
		$display("errors: reset %0d, sync %0d, fetch %0d, pixel %0d, total %0d",
			err_cnt[err_reset], err_cnt[err_sync], err_cnt[err_fetch],
			err_cnt[err_pixel], total_errors());
	endtask

	task automatic check_reset_state;
		assert (read == 1'b0) else report_error(err_reset, "read high in reset");
		assert (hs && vs) else report_error(err_reset, "sync active in reset");
		assert (!de) else report_error(err_reset, "de high in reset");
		assert (r == 6'h00 && g == 6'h00 && b == 6'h00)
		else report_error(err_reset, "colour output not zero in reset");
		assert (addr == base_addr)
		else report_error(err_reset, $sformatf("addr %h in reset, expected %h", addr, base_addr));
	endtask

	// ----------------------------------------------------------------------
	// output monitor, sampled on the falling edge
	// ----------------------------------------------------------------------

	task automatic close_frame(input logic checking);
		if (checking) begin
			assert (line_cnt == v_active)
			else report_error(err_pixel, $sformatf("%0d display lines in frame", line_cnt));
			assert (strobe_cnt == n_words)
			else report_error(err_fetch, $sformatf("%0d read strobes in frame", strobe_cnt));
			for (int i = 0; i < n_pixels; i++) begin
				assert (seen_pix[i] === row_pix[i])
				else report_error(err_pixel, $sformatf("line %0d column %0d is %0b, expected %0b",
					row_line[i], row_col[i], seen_pix[i], row_pix[i]));
			end
		end
		for (int i = 0; i < n_pixels; i++) begin
			seen_pix[i] = 1'bx;
		end
		line_cnt = 0;
		strobe_cnt = 0;
		frame_no++;
	endtask

	task automatic sample_outputs;
		logic checking;
		logic [addr_w-1:0] expect_addr;
		checking = (frame_no == 1) || (frame_no == 3);
		tick++;
		if (!de) begin
			assert (r == 6'h00 && g == 6'h00 && b == 6'h00)
			else report_error(err_pixel, "colour output not blank with de low");
		end else if (checking) begin
			assert ((r == g) && (g == b) && ((r == 6'h00) || (r == 6'h3f)))
			else report_error(err_pixel, $sformatf("colour bits r=%h g=%h b=%h", r, g, b));
		end
		// column and line counting inside the display window
		if (de) begin
			if (checking && (line_cnt < v_active) && (col_cnt < h_active)) begin
				seen_pix[line_cnt * h_active + col_cnt] = r[0];
			end
			col_cnt++;
		end else if (de_q) begin
			if (checking) begin
				assert (col_cnt == h_active)
				else report_error(err_pixel, $sformatf("%0d de cycles on line", col_cnt));
			end
			col_cnt = 0;
			line_cnt++;
		end
		if (read) begin
			assert (bus_cycle == slot_video)
			else report_error(err_fetch, "read strobe outside the video slot");
			if (!read_q) begin
				strobe_cnt++;
			end
			if (checking) begin
				expect_addr = base_addr + addr_w'(4 * (strobe_cnt - 1));
				assert (addr == expect_addr)
				else report_error(err_fetch, $sformatf("read addr %h, expected %h", addr, expect_addr));
			end
		end
		// hs pulse width and line period
		if (!hs && hs_q) begin
			if (checking && hs_fall_seen) begin
				assert (tick - hs_fall_tick == line_len)
				else report_error(err_sync, $sformatf("hs period %0d", tick - hs_fall_tick));
			end
			hs_fall_tick = tick;
			hs_fall_seen = 1'b1;
		end
		if (hs && !hs_q && checking) begin
			assert (tick - hs_fall_tick == h_sync)
			else report_error(err_sync, $sformatf("hs low for %0d", tick - hs_fall_tick));
		end
		// vs is one line long, its fall closes the frame
		if (vs && !vs_q) begin
			assert (tick - vs_fall_tick == line_len)
			else report_error(err_sync, $sformatf("vs low for %0d", tick - vs_fall_tick));
		end
		if (!vs && vs_q) begin
			if (checking && vs_fall_seen) begin
				assert (tick - vs_fall_tick == frame_len)
				else report_error(err_sync, $sformatf("vs period %0d", tick - vs_fall_tick));
			end
			vs_fall_tick = tick;
			vs_fall_seen = 1'b1;
			close_frame(checking);
		end
		de_q = de;
		read_q = read;
		hs_q = hs;
		vs_q = vs;
	endtask

	initial begin : monitor
		@(posedge rst_n);
		forever begin
			@(negedge pclk);
			sample_outputs;
		end
	end

	// ----------------------------------------------------------------------
	// sequence and verdict
	// ----------------------------------------------------------------------

	initial begin : main
		fill_tables;
		repeat (3) @(posedge pclk);
		@(negedge pclk);
		check_reset_state;
		@(posedge pclk);
		rst_n <= 1'b1;
		// knock the bus phase sideways in the middle of frame 2
		wait (frame_no == 2 && line_cnt == 3);
		@(posedge pclk);
		jump_req <= 1'b1;
		@(posedge pclk);
		jump_req <= 1'b0;
		wait (frame_no == n_frames);
		finished = 1'b1;
		print_counts;
		if (total_errors() == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (!finished && (cycles < cycle_limit)) begin
			@(posedge pclk);
			cycles++;
		end
		if (!finished) begin
			$display("timeout after %0d cycles, the frames did not complete", cycles);
			print_counts;
			$display("** FAIL **");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== common/mono_video_pkg.sv ====
`default_nettype none

// shared widths, bus slot encoding and timing constants for the mono video card
package mono_video_pkg;

	// ----------------------------------------------------------------------
	// memory side widths
	// ----------------------------------------------------------------------

	// word address into the shared framebuffer
	localparam int addr_w = 23;
	// one video read returns four 16 bit lanes
	localparam int data_w = 64;

	// ----------------------------------------------------------------------
	// bus rotation
	// ----------------------------------------------------------------------

	// pixel clock step inside one bus slot
	typedef logic [3:0] step_t;
	localparam step_t step_first = 4'h0;
	localparam step_t step_last = 4'hf;

	// owner of the current bus slot, four slots per rotation
	typedef enum logic [1:0] {
		slot_shifter = 2'd0,
		slot_cpu_a = 2'd1,
		slot_video = 2'd2,
		slot_cpu_b = 2'd3
	} bus_slot_e;

	// slot owner in the upper two bits, step below
	localparam int slot_code_w = 6;

	function automatic logic [slot_code_w-1:0] slot_code_of(bus_slot_e slot, step_t step);
		return {slot, step};
	endfunction

	// left back porch, long enough for the first word to reach the shifter
	localparam int h_prefetch = 32;

endpackage

`default_nettype wire

// ==== design/bus_phase.sv ====
`default_nettype none

module bus_phase (
	input logic pclk,
	input logic rst_n,
	input logic bclk,
	input mono_video_pkg::bus_slot_e bus_cycle,
	output logic [mono_video_pkg::slot_code_w-1:0] slot_code
);
	import mono_video_pkg::*;

	// pixel clock step within the current bus slot
	step_t step;
	// step counter may move on this pclk
	logic advance;

	// ----------------------------------------------------------------------
	// phase lock to the bus clock
	// ----------------------------------------------------------------------

	// free running except at the wrap
	// step 15 waits for the low half of bclk
	// step 0 waits for the high half, so 0 sits right after the bclk rise
	always_comb begin
		advance = 1'b1;
		if ((step == step_last) && bclk) begin
			advance = 1'b0;
		end
		if ((step == step_first) && !bclk) begin
			advance = 1'b0;
		end
	end

	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			step <= step_first;
		end else if (advance) begin
			step <= step + 4'd1;
		end
	end

	// ----------------------------------------------------------------------
	// combined slot code
	// ----------------------------------------------------------------------

	// bus slot and step registered together on the rising edge
	// so every consumer sees one stable code per pclk
	// this code lags the raw pair by one pclk
	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			slot_code <= '0;
		end else begin
			slot_code <= slot_code_of(bus_cycle, step);
		end
	end

endmodule

`default_nettype wire

// ==== design/mono_video_top.sv ====
`default_nettype none

module mono_video_top #(
	parameter int h_active = 1280,
	parameter int h_fp = 88,
	parameter int h_sync = 136,
	parameter int h_bp2 = 192,
	parameter int v_active = 1024,
	parameter int v_fp = 9,
	parameter int v_sync = 4,
	parameter int v_bp = 9,
	parameter logic [mono_video_pkg::addr_w-1:0] base_addr = 23'h600000
) (
	input logic pclk,
	input logic rst_n,
	input logic bclk,
	input mono_video_pkg::bus_slot_e bus_cycle,
	output logic [mono_video_pkg::addr_w-1:0] addr,
	output logic read,
	input logic [mono_video_pkg::data_w-1:0] data,
	output logic hs,
	output logic vs,
	output logic de,
	output logic [5:0] r,
	output logic [5:0] g,
	output logic [5:0] b
);
	import mono_video_pkg::*;

	// registered bus slot and step
	logic [slot_code_w-1:0] slot_code;
	// memory enable from the raster
	logic fetch_en;
	// last line but one
	logic frame_end_next;

	// ----------------------------------------------------------------------
	// blocks
	// ----------------------------------------------------------------------

	bus_phase u_bus_phase (
		.pclk(pclk),
		.rst_n(rst_n),
		.bclk(bclk),
		.bus_cycle(bus_cycle),
		.slot_code(slot_code)
	);

	raster_timing #(
		.h_active(h_active),
		.h_fp(h_fp),
		.h_sync(h_sync),
		.h_bp2(h_bp2),
		.v_active(v_active),
		.v_fp(v_fp),
		.v_sync(v_sync),
		.v_bp(v_bp)
	) u_raster_timing (
		.pclk(pclk),
		.rst_n(rst_n),
		.slot_code(slot_code),
		.hs(hs),
		.vs(vs),
		.de(de),
		.fetch_en(fetch_en),
		.frame_end_next(frame_end_next)
	);

	pixel_fetch #(
		.base_addr(base_addr)
	) u_pixel_fetch (
		.pclk(pclk),
		.rst_n(rst_n),
		.slot_code(slot_code),
		.bus_cycle(bus_cycle),
		.fetch_en(fetch_en),
		.de(de),
		.frame_end_next(frame_end_next),
		.data(data),
		.addr(addr),
		.read(read),
		.r(r),
		.g(g),
		.b(b)
	);

endmodule

`default_nettype wire

// ==== design/pixel_fetch.sv ====
`default_nettype none

module pixel_fetch #(
	parameter logic [mono_video_pkg::addr_w-1:0] base_addr = 23'h600000
) (
	input logic pclk,
	input logic rst_n,
	input logic [mono_video_pkg::slot_code_w-1:0] slot_code,
	input mono_video_pkg::bus_slot_e bus_cycle,
	input logic fetch_en,
	input logic de,
	input logic frame_end_next,
	input logic [mono_video_pkg::data_w-1:0] data,
	output logic [mono_video_pkg::addr_w-1:0] addr,
	output logic read,
	output logic [5:0] r,
	output logic [5:0] g,
	output logic [5:0] b
);
	import mono_video_pkg::*;

	// memory holds the word valid up to the end of the video slot
	localparam logic [slot_code_w-1:0] code_latch = slot_code_of(slot_video, step_last);
	// first step after the read
	localparam logic [slot_code_w-1:0] code_advance = slot_code_of(slot_cpu_b, step_first);
	// word moves on to the shifter one slot later, just before its first pixel
	localparam logic [slot_code_w-1:0] code_load = slot_code_of(slot_cpu_b, step_last);

	logic [data_w-1:0] data_reorder;
	logic [data_w-1:0] input_latch;
	logic [data_w-1:0] shift_reg;
	logic pix;

	// strobe straight from the bus slot and the memory enable
	assign read = (bus_cycle == slot_video) && fetch_en;

	// ----------------------------------------------------------------------
	// address
	// ----------------------------------------------------------------------

	// one read is four 16 bit words
	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			addr <= base_addr;
		end else if (frame_end_next) begin
			// rewound during the second to last line, well before line 0
			addr <= base_addr;
		end else if (fetch_en && (slot_code == code_advance)) begin
			addr <= addr + addr_w'(4);
		end
	end

	// ----------------------------------------------------------------------
	// input latch and shifter
	// ----------------------------------------------------------------------

	// lane 0 goes to the top so it is shifted out first
	assign data_reorder = {data[15:0], data[31:16], data[47:32], data[63:48]};

	always_ff @(posedge pclk) begin
		if (fetch_en && (slot_code == code_latch)) begin
			input_latch <= data_reorder;
		end
	end

	// 64 pixels per word, one per pclk, msb first
	always_ff @(posedge pclk) begin
		if (slot_code == code_load) begin
			shift_reg <= input_latch;
		end else begin
			shift_reg <= {shift_reg[data_w-2:0], 1'b0};
		end
	end

	// a set bit is a black pixel
	// blanked outside the display window
	assign pix = de && !shift_reg[data_w-1];

	// same level on every colour bit
	assign r = {6{pix}};
	assign g = {6{pix}};
	assign b = {6{pix}};

endmodule

`default_nettype wire

// ==== design/raster_timing.sv ====
`default_nettype none

module raster_timing #(
	parameter int h_active = 1280,
	parameter int h_fp = 88,
	parameter int h_sync = 136,
	parameter int h_bp2 = 192,
	parameter int v_active = 1024,
	parameter int v_fp = 9,
	parameter int v_sync = 4,
	parameter int v_bp = 9
) (
	input logic pclk,
	input logic rst_n,
	input logic [mono_video_pkg::slot_code_w-1:0] slot_code,
	output logic hs,
	output logic vs,
	output logic de,
	output logic fetch_en,
	output logic frame_end_next
);
	import mono_video_pkg::*;

	// line is prefetch | active | front porch | sync | back porch
	// total must be a multiple of 64 so each line starts on the video slot
	localparam int h_total = h_prefetch + h_active + h_fp + h_sync + h_bp2;
	localparam int v_total = v_active + v_fp + v_sync + v_bp;
	localparam int h_w = $clog2(h_total);
	localparam int v_w = $clog2(v_total);

	localparam logic [h_w-1:0] h_last = h_w'(h_total - 1);
	localparam logic [h_w-1:0] h_de_start = h_w'(h_prefetch);
	localparam logic [h_w-1:0] h_de_end = h_w'(h_prefetch + h_active);
	localparam logic [h_w-1:0] h_hs_start = h_w'(h_prefetch + h_active + h_fp);
	localparam logic [h_w-1:0] h_hs_end = h_w'(h_prefetch + h_active + h_fp + h_sync);
	// end of the video slot in the last 64 pixel block of the active area
	localparam logic [h_w-1:0] h_fetch_stop = h_w'(h_active - 64 + 16);

	localparam logic [v_w-1:0] v_last = v_w'(v_total - 1);
	localparam logic [v_w-1:0] v_act_end = v_w'(v_active);
	localparam logic [v_w-1:0] v_vs_start = v_w'(v_active + v_fp);
	localparam logic [v_w-1:0] v_vs_end = v_w'(v_active + v_fp + v_sync);
	localparam logic [v_w-1:0] v_pre_last = v_w'(v_total - 2);

	// last step of the cpu slot just before the video slot
	localparam logic [slot_code_w-1:0] code_line_start = slot_code_of(slot_cpu_a, step_last);

	logic [h_w-1:0] h_cnt;
	logic [v_w-1:0] v_cnt;
	logic line_end;
	logic line_wrap;
	logic v_act;

	assign line_end = (h_cnt == h_last);
	assign line_wrap = line_end && (slot_code == code_line_start);
	assign v_act = (v_cnt < v_act_end);

	// ----------------------------------------------------------------------
	// counters
	// ----------------------------------------------------------------------

	// h_cnt parks on its last value until the bus rotation catches up
	// so h_cnt 0 always meets video slot step 0
	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (line_end) begin
			if (line_wrap) begin
				h_cnt <= '0;
				v_cnt <= (v_cnt == v_last) ? '0 : v_cnt + v_w'(1);
			end
		end else begin
			h_cnt <= h_cnt + h_w'(1);
		end
	end

	// memory enable, one pclk behind the count it decodes
	// opens at h_cnt 1 and closes after the last video slot of the line
	// so the raw bus slot may lead the code by a pclk without a stray strobe
	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			fetch_en <= 1'b0;
		end else begin
			fetch_en <= v_act && (h_cnt < h_fetch_stop);
		end
	end

	// ----------------------------------------------------------------------
	// decoded outputs
	// ----------------------------------------------------------------------

	// syncs are active low
	assign hs = !((h_cnt >= h_hs_start) && (h_cnt < h_hs_end));
	assign vs = !((v_cnt >= v_vs_start) && (v_cnt < v_vs_end));
	assign de = v_act && (h_cnt >= h_de_start) && (h_cnt < h_de_end);

	// second to last line, time to rewind the address
	assign frame_end_next = (v_cnt == v_pre_last);

endmodule

`default_nettype wire
